/* rtl/cpu_isa_pkg.sv */
// CPU instruction set definitions
// Field positions, opcodes, ALU operations and branch conditions
// of the 16-bit instruction word
package cpu_isa_pkg;

    localparam int data_w     = 16;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    ////////////////////
    // Field positions
    ////////////////////
    localparam int op_lsb    = 11;
    localparam int x_bit_pos = 10;
    localparam int cond_lsb  = 8;
    localparam int ld_ra_lsb = 8;
    localparam int ra_lsb    = 5;
    localparam int rb_lsb    = 0;
    localparam int shamt_w   = 4;
    localparam int imm5_w    = 5;
    localparam int imm8_w    = 8;
    localparam int imm10_w   = 10;

    // ALU group has the top two bits clear, low three bits are the ALU op
    typedef enum logic [4:0] {
        op_add  = 5'b00000,
        op_sub  = 5'b00001,
        op_and  = 5'b00010,
        op_or   = 5'b00011,
        op_xor  = 5'b00100,
        op_sll  = 5'b00101,
        op_srl  = 5'b00110,
        op_sra  = 5'b00111,
        // Low bits 000 so the ALU adds
        op_addi = 5'b01000,
        op_ldu  = 5'b01001,
        op_ldl  = 5'b01010,
        op_ld   = 5'b01011,
        op_st   = 5'b01100,
        op_b    = 5'b01101,
        op_j    = 5'b01110,
        op_ji   = 5'b01111,
        op_halt = 5'b11110,
        op_nop  = 5'b11111
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_op_t;

    typedef enum logic [2:0] {
        cond_eq, cond_ne, cond_gt, cond_lt, cond_ge, cond_le, cond_ov, cond_un
    } cond_t;

    // Jumps save the return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd16;

endpackage

/* rtl/dex_types_pkg.sv */
// Decode/execute stage bundles
// Decoded controls, condition flags, writeback ports and the
// registered stage output
package dex_types_pkg;

    typedef struct packed {
        logic alu_to_reg;
        logic mem_to_reg;
        logic imm_to_reg;
        logic pcr_to_reg;
        logic reg_we_0;
        logic reg_we_1;
        logic reg_read_0;
        logic reg_read_1;
        logic mem_we;
        logic mem_re;
        logic add_immd;
        logic jump_immd;
        logic ldu;
        logic ldl;
        logic branch;
        logic jump;
        logic flags_we;
        logic halt;
    } dex_ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } flags_t;

    typedef struct packed {
        logic                                 we;
        logic [cpu_isa_pkg::reg_addr_w-1:0]   addr;
        logic [cpu_isa_pkg::data_w-1:0]       data;
    } wb_port_t;

    // Everything the memory and writeback stages consume
    typedef struct packed {
        dex_ctrl_t                            ctrl;
        logic [cpu_isa_pkg::reg_addr_w-1:0]   dst_addr_0;
        logic [cpu_isa_pkg::reg_addr_w-1:0]   dst_addr_1;
        logic [cpu_isa_pkg::data_w-1:0]       alu_result;
        logic [cpu_isa_pkg::data_w-1:0]       pc_return;
        logic [cpu_isa_pkg::data_w-1:0]       mem_addr;
        logic [cpu_isa_pkg::data_w-1:0]       mem_wdata;
        logic [cpu_isa_pkg::data_w-1:0]       load_immd;
        logic [cpu_isa_pkg::data_w-1:0]       reg_data_0;
        logic [cpu_isa_pkg::data_w-1:0]       reg_data_1;
        logic                                 valid;
    } dex_out_t;

endpackage

/* rtl/control_unit.sv */
// Instruction decoder
// Turns the opcode and X bit into the stage control bundle
`timescale 1ns/10ps

module control_unit (
    input  cpu_isa_pkg::opcode_t        opcode,
    input  logic                        x_bit,
    output dex_types_pkg::dex_ctrl_t    ctrl
);

    always_comb begin
        ctrl = '0;
        case (opcode)
            // X bit picks the immediate form
            cpu_isa_pkg::op_add, cpu_isa_pkg::op_sub, cpu_isa_pkg::op_and,
            cpu_isa_pkg::op_or, cpu_isa_pkg::op_xor: begin
                ctrl.alu_to_reg = 1'b1;
                ctrl.reg_we_0   = 1'b1;
                ctrl.reg_read_0 = 1'b1;
                ctrl.reg_read_1 = !x_bit;
                ctrl.add_immd   = x_bit;
                ctrl.flags_we   = 1'b1;
            end
            // Shift amount sits in the instruction
            cpu_isa_pkg::op_sll, cpu_isa_pkg::op_srl, cpu_isa_pkg::op_sra: begin
                ctrl.alu_to_reg = 1'b1;
                ctrl.reg_we_0   = 1'b1;
                ctrl.reg_read_0 = 1'b1;
                ctrl.flags_we   = 1'b1;
            end
            cpu_isa_pkg::op_addi: begin
                ctrl.alu_to_reg = 1'b1;
                ctrl.reg_we_0   = 1'b1;
                ctrl.reg_read_0 = 1'b1;
                ctrl.add_immd   = 1'b1;
                ctrl.flags_we   = 1'b1;
            end
            cpu_isa_pkg::op_ldu, cpu_isa_pkg::op_ldl: begin
                ctrl.imm_to_reg = 1'b1;
                ctrl.reg_we_0   = 1'b1;
                ctrl.reg_read_0 = 1'b1;
                ctrl.ldu        = (opcode == cpu_isa_pkg::op_ldu);
                ctrl.ldl        = (opcode == cpu_isa_pkg::op_ldl);
            end
            cpu_isa_pkg::op_ld: begin
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_re     = 1'b1;
                ctrl.reg_we_0   = 1'b1;
                ctrl.reg_read_1 = 1'b1;
            end
            cpu_isa_pkg::op_st: begin
                ctrl.mem_we     = 1'b1;
                ctrl.reg_read_0 = 1'b1;
                ctrl.reg_read_1 = 1'b1;
            end
            cpu_isa_pkg::op_b:    ctrl.branch = 1'b1;
            // Both jumps write the return address to the link register
            cpu_isa_pkg::op_j, cpu_isa_pkg::op_ji: begin
                ctrl.jump       = 1'b1;
                ctrl.pcr_to_reg = 1'b1;
                ctrl.reg_we_1   = 1'b1;
                ctrl.jump_immd  = (opcode == cpu_isa_pkg::op_ji);
                ctrl.reg_read_1 = (opcode == cpu_isa_pkg::op_j);
            end
            cpu_isa_pkg::op_halt: ctrl.halt = 1'b1;
            default:              ctrl = '0;
        endcase
    end

endmodule

/* rtl/register_file.sv */
// General purpose register file
// 32 x 16 bits, two combinational reads, two clocked writes
`timescale 1ns/10ps

module register_file (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [cpu_isa_pkg::reg_addr_w-1:0]    rd_addr_0,
    input  logic [cpu_isa_pkg::reg_addr_w-1:0]    rd_addr_1,
    input  dex_types_pkg::wb_port_t               wb_0,
    input  dex_types_pkg::wb_port_t               wb_1,
    output logic [cpu_isa_pkg::data_w-1:0]        rd_data_0,
    output logic [cpu_isa_pkg::data_w-1:0]        rd_data_1
);

    logic [cpu_isa_pkg::data_w-1:0] regs [cpu_isa_pkg::num_regs];

    // Port 1 is written last so it wins on a shared address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_0.we) begin
                regs[wb_0.addr] <= wb_0.data;
            end
            if (wb_1.we) begin
                regs[wb_1.addr] <= wb_1.data;
            end
        end
    end

    // No bypass, a write shows up the cycle after
    assign rd_data_0 = regs[rd_addr_0];
    assign rd_data_1 = regs[rd_addr_1];

    // Writeback should never aim both ports at one register
    a_no_dual_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_0.we && wb_1.we && (wb_0.addr == wb_1.addr)));

endmodule

/* rtl/alu.sv */
// Integer ALU
// Add, subtract, logic ops and shifts, plus the Z/N/V flag register
`timescale 1ns/10ps

module alu (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cpu_isa_pkg::data_w-1:0]    instr,
    input  dex_types_pkg::dex_ctrl_t          ctrl,
    input  logic [cpu_isa_pkg::data_w-1:0]    reg_data_0,
    input  logic [cpu_isa_pkg::data_w-1:0]    reg_data_1,
    input  logic                              accept,
    output logic [cpu_isa_pkg::data_w-1:0]    result,
    output dex_types_pkg::flags_t             flags
);

    cpu_isa_pkg::alu_op_t                  op;
    logic [cpu_isa_pkg::data_w-1:0]        op_b;
    logic [cpu_isa_pkg::shamt_w-1:0]       shamt;
    logic                                  ovf;
    logic                                  a_msb;
    logic                                  b_msb;

    assign op    = cpu_isa_pkg::alu_op_t'(instr[cpu_isa_pkg::op_lsb +: 3]);
    assign shamt = instr[cpu_isa_pkg::shamt_w-1:0];

    // Second operand, sign extended imm5 or Rs
    assign op_b = ctrl.add_immd ?
        {{(cpu_isa_pkg::data_w - cpu_isa_pkg::imm5_w){instr[cpu_isa_pkg::imm5_w-1]}},
         instr[cpu_isa_pkg::imm5_w-1:0]} :
        reg_data_1;

    assign a_msb = reg_data_0[cpu_isa_pkg::data_w-1];
    assign b_msb = op_b[cpu_isa_pkg::data_w-1];

    always_comb begin
        ovf = 1'b0;
        case (op)
            cpu_isa_pkg::alu_add: begin
                result = reg_data_0 + op_b;
                ovf    = (a_msb == b_msb) && (result[cpu_isa_pkg::data_w-1] != a_msb);
            end
            cpu_isa_pkg::alu_sub: begin
                result = reg_data_0 - op_b;
                ovf    = (a_msb != b_msb) && (result[cpu_isa_pkg::data_w-1] != a_msb);
            end
            cpu_isa_pkg::alu_and: result = reg_data_0 & op_b;
            cpu_isa_pkg::alu_or:  result = reg_data_0 | op_b;
            cpu_isa_pkg::alu_xor: result = reg_data_0 ^ op_b;
            cpu_isa_pkg::alu_sll: result = reg_data_0 << shamt;
            cpu_isa_pkg::alu_srl: result = reg_data_0 >> shamt;
            cpu_isa_pkg::alu_sra: result = $signed(reg_data_0) >>> shamt;
            default:              result = reg_data_0 + op_b;
        endcase
    end

    // Flags only move when a flag setting instruction is accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (accept && ctrl.flags_we) begin
            flags.z <= (result == '0);
            flags.n <= result[cpu_isa_pkg::data_w-1];
            flags.v <= ovf;
        end
    end

endmodule

/* rtl/branch_unit.sv */
// Branch and jump resolution
// Checks the condition code against the flags and picks the next PC
`timescale 1ns/10ps

module branch_unit (
    input  logic [cpu_isa_pkg::data_w-1:0]    instr,
    input  dex_types_pkg::dex_ctrl_t          ctrl,
    input  dex_types_pkg::flags_t             flags,
    input  logic [cpu_isa_pkg::data_w-1:0]    pc_plus_1,
    input  logic [cpu_isa_pkg::data_w-1:0]    reg_data_1,
    output logic                              pc_select,
    output logic [cpu_isa_pkg::data_w-1:0]    pc_next,
    output logic [cpu_isa_pkg::data_w-1:0]    pc_return
);

    cpu_isa_pkg::cond_t                cond;
    logic                              cond_met;
    logic [cpu_isa_pkg::data_w-1:0]    br_target;
    logic [cpu_isa_pkg::data_w-1:0]    ji_target;

    assign cond = cpu_isa_pkg::cond_t'(instr[cpu_isa_pkg::cond_lsb +: 3]);

    // Signed compares after a subtract
    always_comb begin
        case (cond)
            cpu_isa_pkg::cond_eq: cond_met = flags.z;
            cpu_isa_pkg::cond_ne: cond_met = !flags.z;
            cpu_isa_pkg::cond_gt: cond_met = !flags.z && (flags.n == flags.v);
            cpu_isa_pkg::cond_lt: cond_met = (flags.n != flags.v);
            cpu_isa_pkg::cond_ge: cond_met = (flags.n == flags.v);
            cpu_isa_pkg::cond_le: cond_met = flags.z || (flags.n != flags.v);
            cpu_isa_pkg::cond_ov: cond_met = flags.v;
            default:              cond_met = 1'b1;
        endcase
    end

    assign br_target = pc_plus_1 +
        {{(cpu_isa_pkg::data_w - cpu_isa_pkg::imm8_w){instr[cpu_isa_pkg::imm8_w-1]}},
         instr[cpu_isa_pkg::imm8_w-1:0]};
    assign ji_target = pc_plus_1 +
        {{(cpu_isa_pkg::data_w - cpu_isa_pkg::imm10_w){instr[cpu_isa_pkg::imm10_w-1]}},
         instr[cpu_isa_pkg::imm10_w-1:0]};

    assign pc_select = (ctrl.branch && cond_met) || ctrl.jump;
    assign pc_next   = ctrl.branch    ? br_target :
                       ctrl.jump_immd ? ji_target : reg_data_1;
    assign pc_return = pc_plus_1;

endmodule

/* rtl/decode_execute.sv */
// Decode and execute stage
// Decodes one instruction per cycle, reads operands, runs the ALU and
// resolves branches, then captures the results in the DEX register
`timescale 1ns/10ps

module decode_execute (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cpu_isa_pkg::data_w-1:0]    instr,
    input  logic [cpu_isa_pkg::data_w-1:0]    pc_plus_1,
    input  logic                              instr_valid,
    input  dex_types_pkg::wb_port_t           wb_0,
    input  dex_types_pkg::wb_port_t           wb_1,
    output logic                              stall,
    output logic                              pc_select,
    output logic [cpu_isa_pkg::data_w-1:0]    pc_next,
    output dex_types_pkg::dex_out_t           dex
);

    cpu_isa_pkg::opcode_t                  opcode;
    dex_types_pkg::dex_ctrl_t              ctrl;
    dex_types_pkg::flags_t                 flags;
    dex_types_pkg::dex_out_t               dex_d;
    logic [cpu_isa_pkg::reg_addr_w-1:0]    rd_addr_0;
    logic [cpu_isa_pkg::reg_addr_w-1:0]    rd_addr_1;
    logic [cpu_isa_pkg::data_w-1:0]        reg_data_0;
    logic [cpu_isa_pkg::data_w-1:0]        reg_data_1;
    logic [cpu_isa_pkg::data_w-1:0]        alu_result;
    logic [cpu_isa_pkg::data_w-1:0]        pc_return;
    logic [cpu_isa_pkg::data_w-1:0]        load_immd;
    logic                                  br_select;
    logic                                  raw_hazard;
    logic                                  accept;

    // True when a register is still waiting for its write
    function automatic logic addr_pending(
        input logic [cpu_isa_pkg::reg_addr_w-1:0]    addr,
        input dex_types_pkg::dex_out_t               d,
        input dex_types_pkg::wb_port_t               w0,
        input dex_types_pkg::wb_port_t               w1
    );
        logic in_dex;
        logic in_wb;
        in_dex = d.valid && ((d.ctrl.reg_we_0 && (d.dst_addr_0 == addr)) ||
                             (d.ctrl.reg_we_1 && (d.dst_addr_1 == addr)));
        in_wb  = (w0.we && (w0.addr == addr)) || (w1.we && (w1.addr == addr));
        return in_dex || in_wb;
    endfunction

    assign opcode = cpu_isa_pkg::opcode_t'(instr[cpu_isa_pkg::data_w-1:cpu_isa_pkg::op_lsb]);

    control_unit u_ctrl (
        .opcode (opcode),
        .x_bit  (instr[cpu_isa_pkg::x_bit_pos]),
        .ctrl   (ctrl)
    );

    // LDU/LDL name their register with three bits
    assign rd_addr_0 = (ctrl.ldu || ctrl.ldl) ? {2'b00, instr[cpu_isa_pkg::ld_ra_lsb +: 3]} :
                                                instr[cpu_isa_pkg::ra_lsb +: cpu_isa_pkg::reg_addr_w];
    assign rd_addr_1 = instr[cpu_isa_pkg::rb_lsb +: cpu_isa_pkg::reg_addr_w];

    register_file u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_addr_0  (rd_addr_0),
        .rd_addr_1  (rd_addr_1),
        .wb_0       (wb_0),
        .wb_1       (wb_1),
        .rd_data_0  (reg_data_0),
        .rd_data_1  (reg_data_1)
    );

    alu u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .ctrl       (ctrl),
        .reg_data_0 (reg_data_0),
        .reg_data_1 (reg_data_1),
        .accept     (accept),
        .result     (alu_result),
        .flags      (flags)
    );

    branch_unit u_br (
        .instr      (instr),
        .ctrl       (ctrl),
        .flags      (flags),
        .pc_plus_1  (pc_plus_1),
        .reg_data_1 (reg_data_1),
        .pc_select  (br_select),
        .pc_next    (pc_next),
        .pc_return  (pc_return)
    );

    ////////////////////
    // RAW hazard
    ////////////////////
    assign raw_hazard = (ctrl.reg_read_0 && addr_pending(rd_addr_0, dex, wb_0, wb_1)) ||
                        (ctrl.reg_read_1 && addr_pending(rd_addr_1, dex, wb_0, wb_1));
    assign stall     = instr_valid && raw_hazard;
    assign accept    = instr_valid && !stall;
    assign pc_select = br_select && accept;

    // Immediate byte merged with the other byte of the register
    assign load_immd = ctrl.ldu ?
        {instr[cpu_isa_pkg::imm8_w-1:0], reg_data_0[cpu_isa_pkg::imm8_w-1:0]} :
        {reg_data_0[cpu_isa_pkg::data_w-1:cpu_isa_pkg::imm8_w], instr[cpu_isa_pkg::imm8_w-1:0]};

    ////////////////////
    // DEX register
    ////////////////////
    always_comb begin
        dex_d            = '0;
        dex_d.ctrl       = ctrl;
        dex_d.dst_addr_0 = rd_addr_0;
        dex_d.dst_addr_1 = ctrl.jump ? cpu_isa_pkg::link_reg : rd_addr_1;
        dex_d.alu_result = alu_result;
        dex_d.pc_return  = pc_return;
        dex_d.mem_addr   = reg_data_1;
        dex_d.mem_wdata  = reg_data_0;
        dex_d.load_immd  = load_immd;
        dex_d.reg_data_0 = reg_data_0;
        dex_d.reg_data_1 = reg_data_1;
        dex_d.valid      = 1'b1;
    end

    // Stall or idle cycle loads a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || !accept) begin
            dex <= '0;
        end else begin
            dex <= dex_d;
        end
    end

    // Fetch holds a stalled instruction for the retry
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(instr));

endmodule

/* verif/decode_execute_tb.sv */
// Testbench for the decode and execute stage
// Preloads the register file, runs a table of instructions against a
// reference model, then exercises the RAW hazard stall
`timescale 1ns/10ps

module decode_execute_tb;

    typedef struct packed {
        logic [cpu_isa_pkg::data_w-1:0]    instr;
        logic [cpu_isa_pkg::data_w-1:0]    pc;
        dex_types_pkg::dex_out_t           exp_dex;
        logic                              exp_sel;
        logic [cpu_isa_pkg::data_w-1:0]    exp_next;
        logic                              has_target;
        dex_types_pkg::flags_t             exp_flags;
    } entry_t;

    logic                              clk;
    logic                              rst_n;
    logic [cpu_isa_pkg::data_w-1:0]    instr;
    logic [cpu_isa_pkg::data_w-1:0]    pc_plus_1;
    logic                              instr_valid;
    dex_types_pkg::wb_port_t           wb_0;
    dex_types_pkg::wb_port_t           wb_1;
    logic                              stall;
    logic                              pc_select;
    logic [cpu_isa_pkg::data_w-1:0]    pc_next;
    dex_types_pkg::dex_out_t           dex;

    // Reference model state
    logic [cpu_isa_pkg::data_w-1:0]    model_regs [cpu_isa_pkg::num_regs];
    dex_types_pkg::flags_t             model_flags;
    // Signed value that the flags currently describe
    int                                model_val;
    entry_t                            stim_table [$];

    decode_execute u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .pc_plus_1   (pc_plus_1),
        .instr_valid (instr_valid),
        .wb_0        (wb_0),
        .wb_1        (wb_1),
        .stall       (stall),
        .pc_select   (pc_select),
        .pc_next     (pc_next),
        .dex         (dex)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_dex(input dex_types_pkg::dex_out_t exp,
                             input dex_types_pkg::dex_out_t got);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: dex expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_pc(input logic exp_sel, input logic [cpu_isa_pkg::data_w-1:0] exp_next,
                            input logic has_target);
        if (pc_select !== exp_sel) begin
            fail_run($sformatf("CHECK FAILED at %0t: pc_select expected %b got %b",
                               $time, exp_sel, pc_select));
        end
        if (has_target && (pc_next !== exp_next)) begin
            fail_run($sformatf("CHECK FAILED at %0t: pc_next expected %h got %h",
                               $time, exp_next, pc_next));
        end
    endtask

    task automatic check_flags(input dex_types_pkg::flags_t exp, input dex_types_pkg::flags_t got);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: flags expected %b got %b", $time, exp, got));
        end
    endtask

    task automatic check_stall(input logic exp);
        if (stall !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: stall expected %b got %b", $time, exp, stall));
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [cpu_isa_pkg::data_w-1:0] sign_extend(
        input logic [cpu_isa_pkg::data_w-1:0] v,
        input int                             width
    );
        logic [cpu_isa_pkg::data_w-1:0] upper;
        upper = {cpu_isa_pkg::data_w{1'b1}} << width;
        return v[width-1] ? (v | upper) : (v & ~upper);
    endfunction

    // Control bits follow from which operands and results an opcode uses
    function automatic dex_types_pkg::dex_ctrl_t expect_ctrl(
        input logic [cpu_isa_pkg::data_w-1:0] ins
    );
        dex_types_pkg::dex_ctrl_t c;
        logic                     x;
        x = ins[cpu_isa_pkg::x_bit_pos];
        c = '0;
        case (cpu_isa_pkg::opcode_t'(ins[15:11]))
            cpu_isa_pkg::op_add, cpu_isa_pkg::op_sub, cpu_isa_pkg::op_and,
            cpu_isa_pkg::op_or, cpu_isa_pkg::op_xor:
                c = '{alu_to_reg: 1'b1, reg_we_0: 1'b1, reg_read_0: 1'b1, reg_read_1: !x,
                      add_immd: x, flags_we: 1'b1, default: 1'b0};
            cpu_isa_pkg::op_sll, cpu_isa_pkg::op_srl, cpu_isa_pkg::op_sra:
                c = '{alu_to_reg: 1'b1, reg_we_0: 1'b1, reg_read_0: 1'b1, flags_we: 1'b1,
                      default: 1'b0};
            cpu_isa_pkg::op_addi:
                c = '{alu_to_reg: 1'b1, reg_we_0: 1'b1, reg_read_0: 1'b1, add_immd: 1'b1,
                      flags_we: 1'b1, default: 1'b0};
            cpu_isa_pkg::op_ldu:
                c = '{imm_to_reg: 1'b1, reg_we_0: 1'b1, reg_read_0: 1'b1, ldu: 1'b1,
                      default: 1'b0};
            cpu_isa_pkg::op_ldl:
                c = '{imm_to_reg: 1'b1, reg_we_0: 1'b1, reg_read_0: 1'b1, ldl: 1'b1,
                      default: 1'b0};
            cpu_isa_pkg::op_ld:
                c = '{mem_to_reg: 1'b1, mem_re: 1'b1, reg_we_0: 1'b1, reg_read_1: 1'b1,
                      default: 1'b0};
            cpu_isa_pkg::op_st:
                c = '{mem_we: 1'b1, reg_read_0: 1'b1, reg_read_1: 1'b1, default: 1'b0};
            cpu_isa_pkg::op_b:
                c.branch = 1'b1;
            cpu_isa_pkg::op_j:
                c = '{jump: 1'b1, pcr_to_reg: 1'b1, reg_we_1: 1'b1, reg_read_1: 1'b1,
                      default: 1'b0};
            cpu_isa_pkg::op_ji:
                c = '{jump: 1'b1, pcr_to_reg: 1'b1, reg_we_1: 1'b1, jump_immd: 1'b1,
                      default: 1'b0};
            cpu_isa_pkg::op_halt:
                c.halt = 1'b1;
            default:
                c = '0;
        endcase
        return c;
    endfunction

    // Branch outcome from the true signed result of the last flag setter
    function automatic logic cond_holds(
        input logic [2:0] cond,
        input int         val,
        input logic       ovf
    );
        case (cpu_isa_pkg::cond_t'(cond))
            cpu_isa_pkg::cond_eq: return val == 0;
            cpu_isa_pkg::cond_ne: return val != 0;
            cpu_isa_pkg::cond_gt: return val > 0;
            cpu_isa_pkg::cond_lt: return val < 0;
            cpu_isa_pkg::cond_ge: return val >= 0;
            cpu_isa_pkg::cond_le: return val <= 0;
            cpu_isa_pkg::cond_ov: return ovf;
            default:              return 1'b1;
        endcase
    endfunction

    // Predicts one instruction and advances the model flags
    task automatic build_entry(
        input  logic [cpu_isa_pkg::data_w-1:0]    ins,
        input  logic [cpu_isa_pkg::data_w-1:0]    pc,
        output entry_t                            e
    );
        dex_types_pkg::dex_ctrl_t              c;
        logic [cpu_isa_pkg::reg_addr_w-1:0]    ra;
        logic [cpu_isa_pkg::reg_addr_w-1:0]    rb;
        logic [cpu_isa_pkg::data_w-1:0]        a;
        logic [cpu_isa_pkg::data_w-1:0]        b;
        logic [cpu_isa_pkg::data_w-1:0]        res;
        int                                    wide;
        logic                                  ovf;
        c   = expect_ctrl(ins);
        ra  = (c.ldu || c.ldl) ? {2'b00, ins[10:8]} : ins[9:5];
        rb  = ins[4:0];
        a   = model_regs[ra];
        b   = c.add_immd ? sign_extend(ins, 5) : model_regs[rb];
        ovf = 1'b0;
        case (ins[13:11])
            3'd0: begin
                wide = int'($signed(a)) + int'($signed(b));
                ovf  = (wide > 32767) || (wide < -32768);
                res  = wide[15:0];
            end
            3'd1: begin
                wide = int'($signed(a)) - int'($signed(b));
                ovf  = (wide > 32767) || (wide < -32768);
                res  = wide[15:0];
            end
            3'd2:    res = a & b;
            3'd3:    res = a | b;
            3'd4:    res = a ^ b;
            3'd5:    res = a << ins[3:0];
            3'd6:    res = a >> ins[3:0];
            default: res = $signed(a) >>> ins[3:0];
        endcase
        e                    = '0;
        e.instr              = ins;
        e.pc                 = pc;
        e.exp_flags          = model_flags;
        e.exp_dex.ctrl       = c;
        e.exp_dex.dst_addr_0 = ra;
        e.exp_dex.dst_addr_1 = c.jump ? cpu_isa_pkg::link_reg : rb;
        e.exp_dex.alu_result = res;
        e.exp_dex.pc_return  = pc;
        e.exp_dex.mem_addr   = model_regs[rb];
        e.exp_dex.mem_wdata  = a;
        e.exp_dex.load_immd  = c.ldu ? {ins[7:0], a[7:0]} : {a[15:8], ins[7:0]};
        e.exp_dex.reg_data_0 = a;
        e.exp_dex.reg_data_1 = model_regs[rb];
        e.exp_dex.valid      = 1'b1;
        e.exp_sel    = (c.branch && cond_holds(ins[10:8], model_val, model_flags.v)) || c.jump;
        e.exp_next   = c.branch    ? pc + sign_extend(ins, 8) :
                       c.jump_immd ? pc + sign_extend(ins, 10) : model_regs[rb];
        e.has_target = c.branch || c.jump;
        if (c.flags_we) begin
            model_flags.z = (res == '0);
            model_flags.n = res[15];
            model_flags.v = ovf;
            model_val     = (ins[13:12] == 2'b00) ? wide : int'($signed(res));
        end
    endtask

    task automatic wait_dex_valid();
        int cycles;
        cycles = 0;
        while (!dex.valid && (cycles < 20)) begin
            @(negedge clk);
            cycles++;
        end
        if (!dex.valid) begin
            fail_run("timed out waiting for a valid result in dex");
        end
    endtask

    // One instruction followed by an idle cycle so the next entry sees no hazard
    task automatic run_entry(input entry_t e);
        @(negedge clk);
        instr       = e.instr;
        pc_plus_1   = e.pc;
        instr_valid = 1'b1;
        #2;
        check_flags(e.exp_flags, u_dut.flags);
        check_stall(1'b0);
        check_pc(e.exp_sel, e.exp_next, e.has_target);
        @(negedge clk);
        instr_valid = 1'b0;
        wait_dex_valid();
        check_dex(e.exp_dex, dex);
    endtask

    initial begin
        entry_t                            e;
        entry_t                            e_wr;
        logic [cpu_isa_pkg::data_w-1:0]    data;
        int                                sub_ra [8];
        int                                sub_rb [8];
        void'($urandom(32'heb18));
        sub_ra      = '{5, 5, 2, 7, 1, 5, 7, 1};
        sub_rb      = '{6, 6, 1, 8, 2, 6, 8, 2};
        // A jump held with instr_valid low must not select
        instr       = {cpu_isa_pkg::op_ji, 11'd0};
        pc_plus_1   = '0;
        instr_valid = 1'b0;
        wb_0        = '0;
        wb_1        = '0;
        model_flags = '0;
        // Cleared flags describe a positive nonzero value
        model_val   = 1;
        rst_n       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_dex('0, dex);
        check_stall(1'b0);
        check_pc(1'b0, '0, 1'b0);
        check_flags('0, u_dut.flags);

        // r5 equals r6 and r7 minus r8 overflows
        for (int i = 0; i < cpu_isa_pkg::num_regs; i++) begin
            data = 16'($urandom);
            if (i == 6) begin
                data = model_regs[5];
            end else if (i == 7) begin
                data = 16'h8000;
            end else if (i == 8) begin
                data = 16'h0001;
            end
            @(negedge clk);
            wb_0.we       = 1'b1;
            wb_0.addr     = 5'(i);
            wb_0.data     = data;
            model_regs[i] = data;
        end
        @(negedge clk);
        wb_0 = '0;

        ////////////////////
        // Stimulus table
        ////////////////////
        for (int op = 0; op < 8; op++) begin
            for (int x = 0; x < 2; x++) begin
                build_entry({5'(op), 1'(x), 5'($urandom), 5'($urandom)}, 16'($urandom), e);
                stim_table.push_back(e);
            end
        end
        build_entry({cpu_isa_pkg::op_addi, 1'b0, 5'($urandom), 5'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        for (int c = 0; c < 8; c++) begin
            build_entry({cpu_isa_pkg::op_sub, 1'b0, 5'(sub_ra[c]), 5'(sub_rb[c])}, 16'($urandom), e);
            stim_table.push_back(e);
            build_entry({cpu_isa_pkg::op_b, 3'(c), 8'($urandom)}, 16'($urandom), e);
            stim_table.push_back(e);
        end
        build_entry({cpu_isa_pkg::op_j, 6'd0, 5'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        build_entry({cpu_isa_pkg::op_ji, 11'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        build_entry({cpu_isa_pkg::op_ldu, 3'($urandom), 8'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        build_entry({cpu_isa_pkg::op_ldl, 3'($urandom), 8'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        build_entry({cpu_isa_pkg::op_ld, 1'b0, 5'($urandom), 5'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        build_entry({cpu_isa_pkg::op_st, 1'b0, 5'($urandom), 5'($urandom)}, 16'($urandom), e);
        stim_table.push_back(e);
        build_entry({cpu_isa_pkg::op_halt, 11'd0}, 16'($urandom), e);
        stim_table.push_back(e);
        foreach (stim_table[k]) begin
            run_entry(stim_table[k]);
        end

        ////////////////////
        // RAW hazard on r3
        ////////////////////
        build_entry({cpu_isa_pkg::op_add, 1'b0, 5'd3, 5'd4}, 16'h0100, e_wr);
        build_entry({cpu_isa_pkg::op_j, 6'd0, 5'd3}, 16'h0101, e);
        @(negedge clk);
        instr       = e_wr.instr;
        pc_plus_1   = e_wr.pc;
        instr_valid = 1'b1;
        #2;
        check_stall(1'b0);
        @(negedge clk);
        instr     = e.instr;
        pc_plus_1 = e.pc;
        #2;
        check_stall(1'b1);
        check_pc(1'b0, '0, 1'b0);
        // Bubble in dex while fetch still presents the jump
        @(negedge clk);
        check_dex('0, dex);
        check_stall(1'b0);
        check_pc(e.exp_sel, e.exp_next, e.has_target);
        wait_dex_valid();
        check_dex(e.exp_dex, dex);
        instr_valid = 1'b0;

        // Hazard against a write on the writeback port itself
        @(negedge clk);
        wb_1.we       = 1'b1;
        wb_1.addr     = 5'd3;
        wb_1.data     = 16'h1234;
        instr_valid   = 1'b1;
        model_regs[3] = 16'h1234;
        #2;
        check_stall(1'b1);
        @(negedge clk);
        wb_1        = '0;
        instr_valid = 1'b0;
        build_entry({cpu_isa_pkg::op_add, 1'b0, 5'd10, 5'd3}, 16'h0102, e);
        run_entry(e);

        $display("all tests passed");
        $finish;
    end

endmodule

/* decode_execute.f */
rtl/cpu_isa_pkg.sv
rtl/dex_types_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/decode_execute.sv
verif/decode_execute_tb.sv

/* Makefile */
# Verilator build and run of the decode/execute stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module decode_execute_tb \
		-f decode_execute.f -Mdir obj_dir -o decode_execute_sim
	./obj_dir/decode_execute_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
